//--- src/ucpd_rx_pkg.sv
`default_nettype none

package ucpd_rx_pkg;

  // ------------------------------
  // widths and counts
  // ------------------------------

  // every cycle count, interval and threshold
  localparam int UI_W = 11;
  // averaging accumulator, 16 samples of up to two UI each
  localparam int UI_SUM_W = 20;

  // edges per averaging window
  localparam int AVG_LEN = 16;
  localparam int AVG_CNT_W = $clog2(AVG_LEN);

  // preamble edges before completion
  localparam int RX_PRE_EDGES = 192;
  localparam int PRE_CNT_W = $clog2(RX_PRE_EDGES);

  // one 4b5b symbol
  localparam int SYM_BITS = 5;
  localparam int SYM_CNT_W = $clog2(SYM_BITS);

  // ------------------------------
  // types
  // ------------------------------

  typedef logic [UI_W-1:0]     ui_cnt_t;
  typedef logic [UI_SUM_W-1:0] ui_sum_t;

  // phase of the external receive FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PREAMBLE,
    RX_SOP,
    RX_DATA
  } rx_phase_e;

  // bit period trainer FSM
  typedef enum logic [1:0] {
    TR_MEASURE,
    TR_AVERAGE,
    TR_HOLD
  } train_state_e;

  // line filter setup
  typedef struct packed {
    logic filt_short;
    logic filt_bypass;
  } cc_cfg_t;

  // one filtered line transition
  typedef struct packed {
    logic    strobe;
    logic    level;
    ui_cnt_t interval;
  } cc_edge_t;

  // one decoded BMC bit
  typedef struct packed {
    logic valid;
    logic value;
    logic sym_last;
  } rx_bit_t;

endpackage

`default_nettype wire

//--- src/cc_input_cond.sv
`timescale 1ns/10ps
`default_nettype none

module cc_input_cond (
  input  logic                  ucpd_clk,
  input  logic                  ic_rst_n,
  input  logic                  cc_in,
  input  ucpd_rx_pkg::cc_cfg_t  cfg,
  output ucpd_rx_pkg::cc_edge_t cc_edge
);
  import ucpd_rx_pkg::*;

  logic [1:0] sync_q;
  logic       cc_sync;
  logic [3:0] dly_q;
  logic [3:0] tap_mask;
  logic       filt_lvl;
  logic       lvl_q;
  logic       edge_det;
  ui_cnt_t    run_cnt;
  logic       run_max;

  // ------------------------------
  // synchronizer and glitch filter
  // ------------------------------

  // idle line is high, so sync stages come out of reset high
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], cc_in};
    end
  end

  assign cc_sync = sync_q[1];

  // delay line, newest sample in bit 0
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      dly_q <= 4'b1111;
    end else begin
      dly_q <= {dly_q[2:0], cc_sync};
    end
  end

  // two taps in short mode, three otherwise
  assign tap_mask = cfg.filt_short ? 4'b0011 : 4'b0111;

  // any high tap keeps the level high
  // so a low pulse shorter than the window never shows
  assign filt_lvl = cfg.filt_bypass ? cc_sync : |(dly_q & tap_mask);

  // ------------------------------
  // edge detect and run length
  // ------------------------------

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      lvl_q <= 1'b1;
    end else begin
      lvl_q <= filt_lvl;
    end
  end

  assign edge_det = filt_lvl ^ lvl_q;
  assign run_max  = &run_cnt;

  // cycles spent at the current level, held at max
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      run_cnt <= '0;
    end else if (edge_det) begin
      run_cnt <= ui_cnt_t'(1);
    end else if (!run_max) begin
      run_cnt <= run_cnt + ui_cnt_t'(1);
    end
  end

  // registered edge event
  // interval is the length of the level that just ended
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cc_edge <= '{strobe: 1'b0, level: 1'b1, interval: '0};
    end else begin
      cc_edge.strobe   <= edge_det;
      cc_edge.level    <= filt_lvl;
      cc_edge.interval <= run_cnt;
    end
  end

  // between edges the run only grows
  // a rollover would show up as a drop to a short count
  run_saturates: assert property (
    @(posedge ucpd_clk) disable iff (!ic_rst_n)
    !edge_det |=> (run_cnt >= $past(run_cnt))
  );

endmodule

`default_nettype wire

//--- src/ui_trainer.sv
`timescale 1ns/10ps
`default_nettype none

module ui_trainer (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  ucpd_rx_pkg::rx_phase_e rx_phase,
  input  logic                   phy_rx_en,
  input  ucpd_rx_pkg::cc_edge_t  cc_edge,
  output ucpd_rx_pkg::ui_cnt_t   ui_thresh,
  output logic                   rx_pre_cmplt
);
  import ucpd_rx_pkg::*;

  train_state_e         tr_state;
  logic [1:0]           meas_cnt;
  ui_cnt_t              iv_a;
  ui_cnt_t              iv_b;
  ui_cnt_t              period_q;
  ui_sum_t              sum_q;
  logic [AVG_CNT_W-1:0] avg_cnt;
  logic [PRE_CNT_W-1:0] pre_cnt;
  logic                 pre_edge;
  logic                 pre_last;
  logic                 trn_edge;
  logic                 meas_edge;
  logic                 avg_edge;
  logic                 a_big;
  logic                 c_big;
  logic                 align;
  logic                 win_end;
  ui_sum_t              trio_sum;
  ui_cnt_t              trio_period;
  ui_cnt_t              long_min;
  ui_sum_t              edge_est;
  ui_sum_t              win_sum;

  // edges seen while waiting for or inside the preamble
  assign pre_edge = cc_edge.strobe & phy_rx_en &
                    ((rx_phase == RX_IDLE) | (rx_phase == RX_PREAMBLE));
  // training uses preamble edges only
  assign trn_edge  = pre_edge & (rx_phase == RX_PREAMBLE);
  assign meas_edge = trn_edge & (tr_state == TR_MEASURE);
  assign avg_edge  = trn_edge & (tr_state == TR_AVERAGE);

  // ------------------------------
  // phase alignment
  // ------------------------------

  // iv_a, iv_b held, the incoming interval is c
  assign a_big = (iv_a > iv_b) && (iv_a > cc_edge.interval);
  assign c_big = (cc_edge.interval > iv_a) && (cc_edge.interval > iv_b);

  // full UI at either end of the three means a bit boundary lines up
  // long one in the middle means a half bit was lost, slide on
  assign align = meas_edge && (meas_cnt == 2'd3) && (a_big || c_big);

  // one UI plus two half UI, so the bit period is half the sum
  assign trio_sum    = ui_sum_t'(iv_a) + ui_sum_t'(iv_b) + ui_sum_t'(cc_edge.interval);
  assign trio_period = ui_cnt_t'(trio_sum >> 1);

  // ------------------------------
  // window averaging
  // ------------------------------

  // short intervals are half bits, count them twice
  assign long_min = period_q - (period_q >> 2);
  assign edge_est = (cc_edge.interval >= long_min) ?
                    ui_sum_t'(cc_edge.interval) :
                    ui_sum_t'(cc_edge.interval) << 1;

  assign win_sum = sum_q + edge_est;
  assign win_end = avg_edge && (avg_cnt == AVG_CNT_W'(AVG_LEN - 1));

  // interval history and the current period estimate
  always_ff @(posedge ucpd_clk) begin
    if (meas_edge) begin
      iv_a <= iv_b;
      iv_b <= cc_edge.interval;
    end
    if (align) begin
      period_q <= trio_period;
    end else if (win_end) begin
      period_q <= ui_cnt_t'(win_sum >> AVG_CNT_W);
    end
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      tr_state  <= TR_MEASURE;
      meas_cnt  <= '0;
      sum_q     <= '0;
      avg_cnt   <= '0;
      ui_thresh <= '0;
    end else if (rx_phase == RX_IDLE) begin
      tr_state  <= TR_MEASURE;
      meas_cnt  <= '0;
      sum_q     <= '0;
      avg_cnt   <= '0;
      ui_thresh <= '0;
    end else begin
      case (tr_state)
        TR_MEASURE: begin
          if (rx_phase != RX_PREAMBLE) begin
            tr_state <= TR_HOLD;
          end else if (meas_edge) begin
            // first edge closes the idle run, not a bit
            if (meas_cnt != 2'd3) begin
              meas_cnt <= meas_cnt + 2'd1;
            end else if (align) begin
              // aligned trio is the first sample of the window
              sum_q    <= ui_sum_t'(trio_period);
              avg_cnt  <= AVG_CNT_W'(1);
              tr_state <= TR_AVERAGE;
            end
          end
        end
        TR_AVERAGE: begin
          if (rx_phase != RX_PREAMBLE) begin
            tr_state <= TR_HOLD;
          end else if (win_end) begin
            // 3/4 of sum/16
            ui_thresh <= ui_cnt_t'((win_sum + (win_sum << 1)) >> (AVG_CNT_W + 2));
            sum_q     <= '0;
            avg_cnt   <= '0;
          end else if (avg_edge) begin
            sum_q   <= win_sum;
            avg_cnt <= avg_cnt + AVG_CNT_W'(1);
          end
        end
        // threshold frozen until idle
        default: tr_state <= TR_HOLD;
      endcase
    end
  end

  // ------------------------------
  // preamble edge count
  // ------------------------------

  assign pre_last = pre_edge && (pre_cnt == PRE_CNT_W'(RX_PRE_EDGES - 1));

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      pre_cnt      <= '0;
      rx_pre_cmplt <= 1'b0;
    end else begin
      rx_pre_cmplt <= pre_last;
      if (pre_last || (rx_phase == RX_SOP) || (rx_phase == RX_DATA)) begin
        pre_cnt <= '0;
      end else if (pre_edge) begin
        pre_cnt <= pre_cnt + PRE_CNT_W'(1);
      end
    end
  end

  // count restarts after the pulse, so it can not repeat back to back
  pre_cmplt_single: assert property (
    @(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_pre_cmplt |=> !rx_pre_cmplt
  );

endmodule

`default_nettype wire

//--- src/bmc_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bmc_decoder (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  ucpd_rx_pkg::rx_phase_e rx_phase,
  input  ucpd_rx_pkg::cc_edge_t  cc_edge,
  input  ucpd_rx_pkg::ui_cnt_t   ui_thresh,
  output ucpd_rx_pkg::rx_bit_t   rx_bit
);
  import ucpd_rx_pkg::*;

  logic                 dec_en;
  logic                 long_iv;
  logic                 half_q;
  logic                 bit_done;
  logic                 bit_emit;
  logic                 sym_end;
  logic [SYM_CNT_W-1:0] sym_cnt;

  // ------------------------------
  // interval classification
  // ------------------------------

  // bits leave the decoder only past the preamble
  assign dec_en = (rx_phase == RX_SOP) || (rx_phase == RX_DATA);

  // full UI ends a 0, a half UI pair ends a 1
  assign long_iv  = cc_edge.interval >= ui_thresh;
  assign bit_done = cc_edge.strobe & (long_iv | half_q);
  assign bit_emit = bit_done & dec_en;

  // set by the first half of a 1
  // cleared by its second half or by any full UI
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      half_q <= 1'b0;
    end else if (rx_phase == RX_IDLE) begin
      half_q <= 1'b0;
    end else if (cc_edge.strobe) begin
      half_q <= !long_iv && !half_q;
    end
  end

  // ------------------------------
  // symbol framing
  // ------------------------------

  assign sym_end = sym_cnt == SYM_CNT_W'(SYM_BITS - 1);

  // position inside the 5-bit symbol, counted from SOP entry
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sym_cnt <= '0;
    end else if (!dec_en) begin
      sym_cnt <= '0;
    end else if (bit_emit) begin
      sym_cnt <= sym_end ? '0 : sym_cnt + SYM_CNT_W'(1);
    end
  end

  // one cycle strobe after the closing edge
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      rx_bit <= '0;
    end else begin
      rx_bit.valid    <= bit_emit;
      rx_bit.value    <= !long_iv;
      rx_bit.sym_last <= bit_emit & sym_end;
    end
  end

  // decoding needs a trained threshold from the preamble
  thresh_trained: assert property (
    @(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_bit.valid |-> (ui_thresh != '0)
  );

endmodule

`default_nettype wire

//--- src/ucpd_bmc_rx.sv
`timescale 1ns/10ps
`default_nettype none

module ucpd_bmc_rx (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  logic                   cc_in,
  input  ucpd_rx_pkg::cc_cfg_t   cc_cfg,
  input  ucpd_rx_pkg::rx_phase_e rx_phase,
  input  logic                   phy_rx_en,
  output ucpd_rx_pkg::ui_cnt_t   ui_thresh,
  output ucpd_rx_pkg::rx_bit_t   rx_bit,
  output logic                   rx_pre_cmplt
);
  import ucpd_rx_pkg::*;

  // filtered edge events, shared by trainer and decoder
  cc_edge_t cc_edge;

  // ------------------------------
  // line conditioning
  // ------------------------------

  cc_input_cond u_cc_input_cond (
    .ucpd_clk (ucpd_clk),
    .ic_rst_n (ic_rst_n),
    .cc_in    (cc_in),
    .cfg      (cc_cfg),
    .cc_edge  (cc_edge)
  );

  // ------------------------------
  // bit period training
  // ------------------------------

  ui_trainer u_ui_trainer (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .rx_phase     (rx_phase),
    .phy_rx_en    (phy_rx_en),
    .cc_edge      (cc_edge),
    .ui_thresh    (ui_thresh),
    .rx_pre_cmplt (rx_pre_cmplt)
  );

  // threshold also goes out for status
  bmc_decoder u_bmc_decoder (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .rx_phase  (rx_phase),
    .cc_edge   (cc_edge),
    .ui_thresh (ui_thresh),
    .rx_bit    (rx_bit)
  );

endmodule

`default_nettype wire

//--- tests/bmc_line_tasks.svh
`ifndef BMC_LINE_TASKS_SVH
`define BMC_LINE_TASKS_SVH

// ------------------------------
// line timing
// ------------------------------

// step n clocks, landing just after a rising edge
task automatic wait_cycles(input int n);
  repeat (n) begin
    @(posedge ucpd_clk);
    #DRV_DLY;
  end
endtask

// real transition, counted as a line edge
task automatic toggle_line();
  line_lvl   = !line_lvl;
  cc_in      = line_lvl;
  sent_edges = sent_edges + 1;
endtask

// short low pulse, line returns to its held level
// not a line edge, so sent_edges stays put
task automatic inject_glitch(input int len);
  cc_in = 1'b0;
  wait_cycles(len);
  cc_in = line_lvl;
endtask

// ------------------------------
// BMC symbols
// ------------------------------

// half UI at the current level
// glitch only lands on a high level, where the filter must hide it
task automatic hold_half(input bit glitch);
  if (glitch && line_lvl) begin
    wait_cycles(HALF_UI / 2 - 1);
    inject_glitch(1);
    wait_cycles(HALF_UI - HALF_UI / 2);
  end else begin
    wait_cycles(HALF_UI);
  end
endtask

// transition at bit start, extra one mid bit for a 1
task automatic drive_bit(input logic value, input bit glitch);
  toggle_line();
  hold_half(glitch);
  if (value) begin
    toggle_line();
  end
  hold_half(glitch);
endtask

// 0,1,0,1... so even counts chain without a phase slip
task automatic drive_preamble(input int n_bits, input bit glitch);
  int i;
  for (i = 0; i < n_bits; i++) begin
    drive_bit(logic'(i % 2), glitch);
  end
endtask

`endif

//--- tests/tb_ucpd_bmc_rx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ucpd_bmc_rx;
  import ucpd_rx_pkg::*;

  // ------------------------------
  // run constants
  // ------------------------------

  localparam int CLK_PERIOD  = 100;
  localparam int DRV_DLY     = 5;
  localparam int RST_CYCLES  = 3;
  localparam int UI          = 24;
  localparam int HALF_UI     = UI / 2;
  // 128 alternating bits put exactly 192 edges on the line
  localparam int PRE_BITS    = 128;
  // 48 edges, well past the first averaging window
  localparam int PRE_HEAD    = 32;
  localparam int SOP_BITS    = 20;
  localparam int DATA_BITS   = 60;
  localparam int PAY_BITS    = SOP_BITS + DATA_BITS;
  localparam int N_PASS      = 3;
  localparam int IDLE_CYCLES = 16;
  localparam int DRAIN_LIMIT = 2 * UI;
  localparam int THRESH_EXP  = (3 * UI) / 4;
  localparam int THRESH_TOL  = 2;
  // all bits plus the closing edge, idle gap and drain per pass
  localparam int PASS_CYCLES = (PRE_BITS + PAY_BITS + 1) * UI + 2 * IDLE_CYCLES + DRAIN_LIMIT;
  localparam int WATCHDOG_NS = (N_PASS * PASS_CYCLES + 200) * CLK_PERIOD;

  logic      ucpd_clk;
  logic      ic_rst_n;
  logic      cc_in;
  cc_cfg_t   cc_cfg;
  rx_phase_e rx_phase;
  logic      phy_rx_en;
  ui_cnt_t   ui_thresh;
  rx_bit_t   rx_bit;
  logic      rx_pre_cmplt;

  // line model
  logic   line_lvl;
  int     sent_edges;
  // scoreboard
  logic   exp_q[$];
  logic   exp_head;
  int     exp_cnt;
  int     pre_pulses;
  int     bit_idx;
  logic   prev_bit;
  logic   pay_bits [PAY_BITS];
  // check windows
  logic   idle_chk;
  logic   thresh_chk;
  integer seed;

  `include "bmc_line_tasks.svh"

  ucpd_bmc_rx DUT (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .cc_in        (cc_in),
    .cc_cfg       (cc_cfg),
    .rx_phase     (rx_phase),
    .phy_rx_en    (phy_rx_en),
    .ui_thresh    (ui_thresh),
    .rx_bit       (rx_bit),
    .rx_pre_cmplt (rx_pre_cmplt)
  );

  always #(CLK_PERIOD / 2) ucpd_clk = !ucpd_clk;

  // ------------------------------
  // error exits
  // ------------------------------

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  // ------------------------------
  // scoreboard
  // ------------------------------

  task automatic refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : 1'b0;
  endtask

  task automatic expect_bit(input logic value);
    exp_q.push_back(value);
    refresh_head();
  endtask

  // pulse count, bit position since SOP entry, pop on each decoded bit
  always @(posedge ucpd_clk) begin
    if (rx_pre_cmplt) begin
      pre_pulses = pre_pulses + 1;
    end
    if (rx_phase != RX_SOP && rx_phase != RX_DATA) begin
      bit_idx = 0;
    end else if (rx_bit.valid) begin
      bit_idx = bit_idx + 1;
    end
    if (rx_bit.valid && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  idle_quiet: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    idle_chk |-> (!rx_bit.valid && !rx_pre_cmplt && ui_thresh == '0))
    else report_error("output active while the line idles");

  // glitches never count, so the pulse sits on the 192nd real edge
  pre_on_last_edge: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_pre_cmplt |-> (sent_edges == RX_PRE_EDGES))
    else report_error($sformatf("preamble done after %0d edges", $sampled(sent_edges)));

  thresh_range: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    thresh_chk |-> (int'(ui_thresh) >= THRESH_EXP - THRESH_TOL &&
                    int'(ui_thresh) <= THRESH_EXP + THRESH_TOL))
    else report_error($sformatf("threshold %0d, expected near %0d",
                                $sampled(ui_thresh), THRESH_EXP));

  valid_phase: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_bit.valid |-> (rx_phase == RX_SOP || rx_phase == RX_DATA))
    else report_error("decoded bit outside SOP or data phase");

  valid_value: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_bit.valid |-> (exp_cnt != 0 && rx_bit.value == exp_head))
    else report_error($sformatf("bit %0d decoded as %0b, expected %0b",
                                $sampled(bit_idx), $sampled(rx_bit.value), $sampled(exp_head)));

  sym_marker: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_bit.valid |-> (rx_bit.sym_last == ((bit_idx % SYM_BITS) == SYM_BITS - 1)))
    else report_error($sformatf("symbol marker wrong on bit %0d", $sampled(bit_idx)));

  idle_clears: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    (rx_phase == RX_IDLE) |=> (ui_thresh == '0))
    else report_error("threshold kept after idle");

  // ------------------------------
  // sequences
  // ------------------------------

  task automatic check_idle();
    wait_cycles(2);
    idle_chk = 1'b1;
    wait_cycles(IDLE_CYCLES);
    idle_chk = 1'b0;
  endtask

  // edge at this bit's start closes the previous one
  task automatic send_payload_bit(input logic value, input bit glitch);
    expect_bit(prev_bit);
    drive_bit(value, glitch);
    prev_bit = value;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_cnt != 0 && n < DRAIN_LIMIT) begin
      wait_cycles(1);
      n++;
    end
    if (exp_cnt != 0) begin
      abort_run("timed out waiting for the last decoded bit");
    end
  endtask

  task automatic run_pass(input cc_cfg_t cfg, input bit glitch);
    int i;
    cc_cfg = cfg;
    wait_cycles(4);
    sent_edges = 0;
    pre_pulses = 0;
    phy_rx_en  = 1'b1;
    rx_phase   = RX_PREAMBLE;
    drive_preamble(PRE_HEAD, glitch);
    thresh_chk = 1'b1;
    drive_preamble(PRE_BITS - PRE_HEAD, glitch);
    // boundary edge ends the last preamble bit, a 1
    rx_phase = RX_SOP;
    prev_bit = 1'b1;
    for (i = 0; i < PAY_BITS; i++) begin
      if (i == SOP_BITS) begin
        rx_phase = RX_DATA;
      end
      send_payload_bit(pay_bits[i], glitch);
    end
    // one more edge to end the final data bit
    expect_bit(prev_bit);
    toggle_line();
    wait_drain();
    assert (pre_pulses == 1)
      else report_error($sformatf("%0d preamble done pulses", pre_pulses));
    thresh_chk = 1'b0;
    rx_phase   = RX_IDLE;
    phy_rx_en  = 1'b0;
    // back to a high idle line, edge not counted
    if (!line_lvl) begin
      toggle_line();
    end
    check_idle();
  endtask

  initial begin
    int i;
    integer rnd;
    seed       = 32'h944f;
    ucpd_clk   = 1'b0;
    ic_rst_n   = 1'b0;
    cc_in      = 1'b1;
    line_lvl   = 1'b1;
    cc_cfg     = '0;
    rx_phase   = RX_IDLE;
    phy_rx_en  = 1'b0;
    sent_edges = 0;
    pre_pulses = 0;
    bit_idx    = 0;
    prev_bit   = 1'b1;
    idle_chk   = 1'b0;
    thresh_chk = 1'b0;
    exp_q.delete();
    refresh_head();
    // same payload in every pass
    for (i = 0; i < PAY_BITS; i++) begin
      rnd = $random(seed);
      pay_bits[i] = rnd[0];
    end
    repeat (RST_CYCLES) @(posedge ucpd_clk);
    #DRV_DLY;
    ic_rst_n = 1'b1;
    check_idle();
    // three tap, two tap, then no filter and a clean line
    run_pass('{filt_short: 1'b0, filt_bypass: 1'b0}, 1'b1);
    run_pass('{filt_short: 1'b1, filt_bypass: 1'b0}, 1'b1);
    run_pass('{filt_short: 1'b0, filt_bypass: 1'b1}, 1'b0);
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired, the run timed out");
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+tests
src/ucpd_rx_pkg.sv
src/cc_input_cond.sv
src/ui_trainer.sv
src/bmc_decoder.sv
src/ucpd_bmc_rx.sv
tests/tb_ucpd_bmc_rx.sv

//--- Bender.yml
package:
  name: ucpd_bmc_rx

sources:
  - src/ucpd_rx_pkg.sv
  - src/cc_input_cond.sv
  - src/ui_trainer.sv
  - src/bmc_decoder.sv
  - src/ucpd_bmc_rx.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_ucpd_bmc_rx.sv
